// ==== src/iss_pkg.sv ====
`default_nettype none

package iss_pkg;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // Data word, also used for PCs
  typedef logic [31:0] word_t;

  // ROB depth is 2**rob_idx_w
  localparam int rob_idx_w = 4;

  typedef logic [rob_idx_w-1:0] rob_slot_t;

  // Execution class, selects the unit an instruction can go to
  typedef enum logic [2:0] {
    cls_alu,
    cls_muldiv,
    cls_mem,
    cls_branch,
    cls_jump
  } inst_class_e;

  // Branch conditions, the ordered ones test A against zero
  typedef enum logic [2:0] {
    cond_always,
    cond_eq,
    cond_ne,
    cond_gt,
    cond_ge,
    cond_lt,
    cond_le
  } branch_cond_e;

  typedef struct packed {
    word_t        pc;
    word_t        inst_word;
    reg_addr_t    a_reg;
    logic         a_reg_valid;
    reg_addr_t    b_reg;
    logic         b_reg_valid;
    reg_addr_t    dest_reg;
    logic         dest_reg_valid;
    inst_class_e  inst_class;
    branch_cond_e branch_cond;
    // Jump target taken from operand A
    logic         reg_target;
    word_t        branch_target;
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t dec_inst;
    rob_slot_t rob_slot;
  } iq_entry_t;

  // ROB answer for one operand
  typedef struct packed {
    word_t value;
    logic  valid;
    logic  present;
  } rob_lookup_t;

  typedef struct packed {
    dec_inst_t inst;
    word_t     a;
    word_t     b;
    rob_slot_t rob_slot;
    logic      valid;
  } issue_op_t;

  // Link write from the branch unit into the ROB
  typedef struct packed {
    rob_slot_t slot;
    word_t     result;
    reg_addr_t dest_reg;
    logic      dest_reg_valid;
    logic      pc_valid;
  } rob_write_t;

endpackage

`default_nettype wire

// ==== src/iss_operand_read.sv ====
`default_nettype none

module iss_operand_read #(
  parameter int issue_width = 4
) (
  input  wire iss_pkg::iq_entry_t   entries   [issue_width],
  input  wire iss_pkg::rob_lookup_t rob_a     [issue_width],
  input  wire iss_pkg::rob_lookup_t rob_b     [issue_width],
  input  wire iss_pkg::word_t       rf_data   [2*issue_width],
  output iss_pkg::reg_addr_t        rf_addr   [2*issue_width],
  output iss_pkg::word_t            op_a      [issue_width],
  output iss_pkg::word_t            op_b      [issue_width],
  output logic                      ops_ready [issue_width]
);
  import iss_pkg::*;

  dec_inst_t di      [issue_width];
  logic      a_valid [issue_width];
  logic      b_valid [issue_width];

  for (genvar i = 0; i < issue_width; i++) begin : g_slot
    assign di[i] = entries[i].dec_inst;

    // Even read port carries A, odd read port carries B
    assign rf_addr[2*i]   = di[i].a_reg;
    assign rf_addr[2*i+1] = di[i].b_reg;

    // ROB holds the newer value whenever the register is present there
    assign op_a[i] = rob_a[i].present ? rob_a[i].value : rf_data[2*i];
    assign op_b[i] = rob_b[i].present ? rob_b[i].value : rf_data[2*i+1];

    // Not in the ROB means the register file copy is up to date
    assign a_valid[i] = ~rob_a[i].present | rob_a[i].valid;
    assign b_valid[i] = ~rob_b[i].present | rob_b[i].valid;

    // Operands the instruction does not use never hold it back
    assign ops_ready[i] = (a_valid[i] | ~di[i].a_reg_valid) &
                          (b_valid[i] | ~di[i].b_reg_valid);
  end

endmodule

`default_nettype wire

// ==== src/iss_dispatch.sv ====
`default_nettype none

module iss_dispatch #(
  parameter int issue_width = 4,
  parameter int alu_count   = 1
) (
  input  wire iss_pkg::iq_entry_t entries      [issue_width],
  input  wire                     entry_valid  [issue_width],
  input  wire iss_pkg::word_t     op_a         [issue_width],
  input  wire iss_pkg::word_t     op_b         [issue_width],
  input  wire                     ops_ready    [issue_width],
  input  wire                     branch_ready,
  input  wire                     ls_ready,
  input  wire                     alu_ready    [alu_count],
  input  wire                     mul_ready,
  output logic                    consumed     [issue_width],
  output logic                    issue_enable,
  output iss_pkg::issue_op_t      branch_issue,
  output iss_pkg::issue_op_t      ls_issue,
  output iss_pkg::issue_op_t      alu_issue    [alu_count],
  output iss_pkg::issue_op_t      mul_issue
);
  import iss_pkg::*;

  function automatic issue_op_t make_op(iq_entry_t entry, word_t a, word_t b);
    issue_op_t op;
    op.inst     = entry.dec_inst;
    op.a        = a;
    op.b        = b;
    op.rob_slot = entry.rob_slot;
    op.valid    = 1'b1;
    return op;
  endfunction

  // Strictly in-order scan, the first slot that cannot go stops the rest
  always_comb begin : route
    logic                 stop;
    logic                 placed;
    logic                 branch_used;
    logic                 ls_used;
    logic                 mul_used;
    logic [alu_count-1:0] alu_used;
    issue_op_t            op;

    stop        = 1'b0;
    branch_used = 1'b0;
    ls_used     = 1'b0;
    mul_used    = 1'b0;
    alu_used    = '0;

    branch_issue = '0;
    ls_issue     = '0;
    mul_issue    = '0;
    for (int k = 0; k < alu_count; k++) begin
      alu_issue[k] = '0;
    end
    issue_enable = 1'b0;

    for (int i = 0; i < issue_width; i++) begin
      op     = make_op(entries[i], op_a[i], op_b[i]);
      placed = 1'b0;

      if (!stop && entry_valid[i] && ops_ready[i]) begin
        case (entries[i].dec_inst.inst_class)
          cls_branch, cls_jump: begin
            // One branch per cycle
            if (!branch_used && branch_ready) begin
              branch_issue = op;
              branch_used  = 1'b1;
              placed       = 1'b1;
            end
          end
          cls_mem: begin
            if (!ls_used && ls_ready) begin
              ls_issue = op;
              ls_used  = 1'b1;
              placed   = 1'b1;
            end
          end
          cls_muldiv: begin
            if (!mul_used && mul_ready) begin
              mul_issue = op;
              mul_used  = 1'b1;
              placed    = 1'b1;
            end
          end
          cls_alu: begin
            // Lowest free ALU wins
            for (int k = 0; k < alu_count; k++) begin
              if (!placed && !alu_used[k] && alu_ready[k]) begin
                alu_issue[k] = op;
                alu_used[k]  = 1'b1;
                placed       = 1'b1;
              end
            end
            // All ALUs taken, the mul/div unit can run plain ALU ops too
            if (!placed && !mul_used && mul_ready) begin
              mul_issue = op;
              mul_used  = 1'b1;
              placed    = 1'b1;
            end
          end
          default: begin
            placed = 1'b0;
          end
        endcase
      end

      consumed[i]  = placed;
      stop         = stop | ~placed;
      issue_enable = issue_enable | placed;
    end
  end

endmodule

`default_nettype wire

// ==== src/iss_branch.sv ====
`default_nettype none

module iss_branch (
  input  wire                     clock,
  input  wire                     reset_n,
  input  wire iss_pkg::issue_op_t branch_issue,
  input  wire                     branch_stall,
  output logic                    branch_ready,
  output iss_pkg::word_t          new_pc,
  output logic                    new_pc_valid,
  output logic                    branch_flush,
  output iss_pkg::rob_slot_t      flush_slot,
  output iss_pkg::rob_write_t     rob_wr,
  output logic                    rob_wr_valid
);
  import iss_pkg::*;

  logic      stall_q;
  logic      capture;
  logic      held_valid;
  issue_op_t held_op;
  issue_op_t act;
  logic      ab_equal;
  logic      a_eqz;
  logic      a_gez;
  logic      a_gtz;
  logic      cond_ok;
  word_t     pc_plus_8;

  // Take a copy of the branch on the first cycle of a fetch stall
  assign capture = branch_stall & ~stall_q;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_q    <= 1'b0;
      held_valid <= 1'b0;
    end else begin
      stall_q <= branch_stall;
      if (capture) begin
        held_valid <= branch_issue.valid;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      held_op <= branch_issue;
    end
  end

  // No new branch while the held copy is being worked on
  assign branch_ready = ~stall_q;

  always_comb begin
    act = branch_issue;
    if (stall_q) begin
      act       = held_op;
      act.valid = held_valid;
    end
  end

  assign ab_equal = (act.a == act.b);
  assign a_eqz    = (act.a == '0);
  assign a_gez    = ~act.a[31];
  assign a_gtz    = a_gez & ~a_eqz;

  always_comb begin
    case (act.inst.branch_cond)
      cond_always: cond_ok = 1'b1;
      cond_eq:     cond_ok = ab_equal;
      cond_ne:     cond_ok = ~ab_equal;
      cond_gt:     cond_ok = a_gtz;
      cond_ge:     cond_ok = a_gez;
      cond_lt:     cond_ok = ~a_gez;
      cond_le:     cond_ok = ~a_gtz;
      default:     cond_ok = 1'b0;
    endcase
  end

  assign new_pc_valid = act.valid &
                        ((act.inst.inst_class == cls_jump) |
                         ((act.inst.inst_class == cls_branch) & cond_ok));
  assign new_pc = act.inst.reg_target ? act.a : act.inst.branch_target;

  // A held branch already flushed when it was first seen
  assign branch_flush = new_pc_valid & ~stall_q;
  assign flush_slot   = act.rob_slot;

  // Link value skips the branch and its delay slot
  assign pc_plus_8 = act.inst.pc + 32'd8;

  assign rob_wr.slot           = act.rob_slot;
  assign rob_wr.result         = pc_plus_8;
  assign rob_wr.dest_reg       = act.inst.dest_reg;
  assign rob_wr.dest_reg_valid = act.inst.dest_reg_valid;
  assign rob_wr.pc_valid       = new_pc_valid;
  assign rob_wr_valid          = act.valid & ~branch_stall;

endmodule

`default_nettype wire

// ==== src/iss_top.sv ====
`default_nettype none

module iss_top #(
  parameter int issue_width = 4,
  parameter int alu_count   = 1
) (
  input  wire                       clock,
  input  wire                       reset_n,

  // Instruction queue head
  input  wire iss_pkg::iq_entry_t   entries      [issue_width],
  input  wire                       entry_valid  [issue_width],
  output logic                      consumed     [issue_width],
  output logic                      issue_enable,

  // ROB lookup and register file read
  input  wire iss_pkg::rob_lookup_t rob_a        [issue_width],
  input  wire iss_pkg::rob_lookup_t rob_b        [issue_width],
  output iss_pkg::reg_addr_t        rf_addr      [2*issue_width],
  input  wire iss_pkg::word_t       rf_data      [2*issue_width],

  // Execution units
  input  wire                       ls_ready,
  input  wire                       alu_ready    [alu_count],
  input  wire                       mul_ready,
  output iss_pkg::issue_op_t        ls_issue,
  output iss_pkg::issue_op_t        alu_issue    [alu_count],
  output iss_pkg::issue_op_t        mul_issue,

  // Fetch redirect and ROB link write
  input  wire                       branch_stall,
  output iss_pkg::word_t            new_pc,
  output logic                      new_pc_valid,
  output logic                      branch_flush,
  output iss_pkg::rob_slot_t        flush_slot,
  output iss_pkg::rob_write_t       rob_wr,
  output logic                      rob_wr_valid
);
  import iss_pkg::*;

  word_t     op_a      [issue_width];
  word_t     op_b      [issue_width];
  logic      ops_ready [issue_width];
  issue_op_t branch_issue;
  logic      branch_ready;

  iss_operand_read #(
    .issue_width (issue_width)
  ) u_operand_read (
    .entries   (entries),
    .rob_a     (rob_a),
    .rob_b     (rob_b),
    .rf_data   (rf_data),
    .rf_addr   (rf_addr),
    .op_a      (op_a),
    .op_b      (op_b),
    .ops_ready (ops_ready)
  );

  iss_dispatch #(
    .issue_width (issue_width),
    .alu_count   (alu_count)
  ) u_dispatch (
    .entries      (entries),
    .entry_valid  (entry_valid),
    .op_a         (op_a),
    .op_b         (op_b),
    .ops_ready    (ops_ready),
    .branch_ready (branch_ready),
    .ls_ready     (ls_ready),
    .alu_ready    (alu_ready),
    .mul_ready    (mul_ready),
    .consumed     (consumed),
    .issue_enable (issue_enable),
    .branch_issue (branch_issue),
    .ls_issue     (ls_issue),
    .alu_issue    (alu_issue),
    .mul_issue    (mul_issue)
  );

  iss_branch u_branch (
    .clock        (clock),
    .reset_n      (reset_n),
    .branch_issue (branch_issue),
    .branch_stall (branch_stall),
    .branch_ready (branch_ready),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .branch_flush (branch_flush),
    .flush_slot   (flush_slot),
    .rob_wr       (rob_wr),
    .rob_wr_valid (rob_wr_valid)
  );

endmodule

`default_nettype wire

// ==== dv/iss_model.svh ====
// Unit numbering in the model: branch, load/store, mul/div, then the ALUs
localparam int unit_branch = 0;
localparam int unit_ls     = 1;
localparam int unit_mul    = 2;
localparam int unit_alu    = 3;

// Model copy of the branch unit state
logic      model_stall;
issue_op_t model_held;

// The ROB copy is newer whenever the register is present there
function automatic word_t operand_value(rob_lookup_t rob, word_t rf);
  return rob.present ? rob.value : rf;
endfunction

function automatic logic operand_ok(rob_lookup_t rob, logic used);
  return !used || !rob.present || rob.valid;
endfunction

// Returns the unit index for one instruction, or -1 when nothing is free
function automatic int pick_unit(inst_class_e cls, logic [n_units-1:0] free);
  int unit;
  unit = -1;
  case (cls)
    cls_branch, cls_jump: unit = free[unit_branch] ? unit_branch : -1;
    cls_mem:              unit = free[unit_ls] ? unit_ls : -1;
    cls_muldiv:           unit = free[unit_mul] ? unit_mul : -1;
    cls_alu: begin
      for (int k = n_units - 1; k >= unit_alu; k--) begin
        if (free[k]) begin
          unit = k;
        end
      end
      // ALU overflow
      if (unit < 0 && free[unit_mul]) begin
        unit = unit_mul;
      end
    end
    default: unit = -1;
  endcase
  return unit;
endfunction

function automatic issue_op_t build_op(iq_entry_t e, word_t a, word_t b);
  issue_op_t op;
  op.inst     = e.dec_inst;
  op.a        = a;
  op.b        = b;
  op.rob_slot = e.rob_slot;
  op.valid    = 1'b1;
  return op;
endfunction

function automatic logic cond_taken(branch_cond_e cond, word_t a, word_t b);
  logic signed [31:0] sa;
  sa = a;
  case (cond)
    cond_always: return 1'b1;
    cond_eq:     return a == b;
    cond_ne:     return a != b;
    cond_gt:     return sa > 0;
    cond_ge:     return sa >= 0;
    cond_lt:     return sa < 0;
    cond_le:     return sa <= 0;
    default:     return 1'b0;
  endcase
endfunction

function automatic logic redirects(issue_op_t op);
  return op.valid && (op.inst.inst_class == cls_jump ||
         (op.inst.inst_class == cls_branch && cond_taken(op.inst.branch_cond, op.a, op.b)));
endfunction

function automatic word_t redirect_pc(issue_op_t op);
  return op.inst.reg_target ? op.a : op.inst.branch_target;
endfunction

function automatic rob_write_t link_write(issue_op_t op, logic taken);
  rob_write_t wr;
  wr.slot           = op.rob_slot;
  wr.result         = op.inst.pc + 32'd8;
  wr.dest_reg       = op.inst.dest_reg;
  wr.dest_reg_valid = op.inst.dest_reg_valid;
  wr.pc_valid       = taken;
  return wr;
endfunction

task automatic reset_model();
  model_stall = 1'b0;
  model_held  = '0;
endtask

// Clock edge of the model, capture on the first stalled cycle
task automatic advance_model(logic stall, issue_op_t branch_op);
  if (stall && !model_stall) begin
    model_held = branch_op;
  end
  model_stall = stall;
endtask

// ==== dv/iss_tb.sv ====
`default_nettype none

module iss_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import iss_pkg::*;

  localparam int issue_w    = 4;
  localparam int alu_n      = 2;
  localparam int n_units    = 3 + alu_n;
  localparam int clk_period = 40;
  localparam int n_cycles   = 2000;

  logic        clock;
  logic        reset_n;
  iq_entry_t   entries      [issue_w];
  logic        entry_valid  [issue_w];
  logic        consumed     [issue_w];
  logic        issue_enable;
  rob_lookup_t rob_a        [issue_w];
  rob_lookup_t rob_b        [issue_w];
  reg_addr_t   rf_addr      [2*issue_w];
  word_t       rf_data      [2*issue_w];
  logic        ls_ready;
  logic        alu_ready    [alu_n];
  logic        mul_ready;
  issue_op_t   ls_issue;
  issue_op_t   alu_issue    [alu_n];
  issue_op_t   mul_issue;
  logic        branch_stall;
  word_t       new_pc;
  logic        new_pc_valid;
  logic        branch_flush;
  rob_slot_t   flush_slot;
  rob_write_t  rob_wr;
  logic        rob_wr_valid;

  integer    seed;
  int        n_checks;
  int        n_errors;
  issue_op_t exp_branch;

  `include "iss_model.svh"

  iss_top #(.issue_width(issue_w), .alu_count(alu_n)) DUT (.*);

  initial clock = 1'b0;
  always #(clk_period / 2) clock = ~clock;

  initial begin
    reset_n = 1'b0;
    repeat (3) @(negedge clock);
    reset_n = 1'b1;
  end

  task automatic expect_hex(string name, logic [191:0] act, logic [191:0] exp);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic compare_port(string name, issue_op_t act, issue_op_t exp);
    expect_hex({name, ".valid"}, act.valid, exp.valid);
    if (exp.valid) begin
      expect_hex(name, act, exp);
    end
  endtask

  // Small values and zero show up often so eq and sign tests hit both ways
  function automatic word_t draw_word();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return '0;
      2'd1:    return {{26{r[7]}}, r[7:2]};
      default: return $random(seed);
    endcase
  endfunction

  function automatic iq_entry_t draw_entry();
    iq_entry_t   e;
    logic [31:0] r;
    r = $random(seed);
    e.dec_inst.a_reg          = r[4:0];
    e.dec_inst.a_reg_valid    = r[5];
    e.dec_inst.b_reg          = r[10:6];
    e.dec_inst.b_reg_valid    = r[11];
    e.dec_inst.dest_reg       = r[16:12];
    e.dec_inst.dest_reg_valid = r[17];
    e.dec_inst.reg_target     = r[18];
    e.rob_slot                = r[22:19];
    r = $unsigned($random(seed)) % 5;
    e.dec_inst.inst_class = inst_class_e'(r[2:0]);
    r = $unsigned($random(seed)) % 7;
    e.dec_inst.branch_cond   = branch_cond_e'(r[2:0]);
    e.dec_inst.pc            = {$random(seed)} & 32'hffff_fffc;
    e.dec_inst.inst_word     = $random(seed);
    e.dec_inst.branch_target = {$random(seed)} & 32'hffff_fffc;
    return e;
  endfunction

  task automatic clear_inputs();
    for (int i = 0; i < issue_w; i++) begin
      entries[i]     = '0;
      entry_valid[i] = 1'b0;
      rob_a[i]       = '0;
      rob_b[i]       = '0;
    end
    for (int j = 0; j < 2 * issue_w; j++) begin
      rf_data[j] = '0;
    end
    for (int k = 0; k < alu_n; k++) begin
      alu_ready[k] = 1'b1;
    end
    ls_ready     = 1'b1;
    mul_ready    = 1'b1;
    branch_stall = 1'b0;
  endtask

  task automatic draw_stimulus();
    logic [31:0] r;
    int          count;
    count = $unsigned($random(seed)) % (issue_w + 1);
    for (int i = 0; i < issue_w; i++) begin
      entries[i]     = draw_entry();
      entry_valid[i] = (i < count);
      r = $random(seed);
      rob_a[i].present = r[0];
      rob_a[i].valid   = |r[2:1];
      rob_b[i].present = r[3];
      rob_b[i].valid   = |r[5:4];
      rob_a[i].value   = draw_word();
      rob_b[i].value   = draw_word();
    end
    for (int j = 0; j < 2 * issue_w; j++) begin
      rf_data[j] = draw_word();
    end
    r = $random(seed);
    ls_ready  = |r[1:0];
    mul_ready = |r[3:2];
    for (int k = 0; k < alu_n; k++) begin
      alu_ready[k] = r[4+2*k] | r[5+2*k];
    end
    // Fetch stalls are rare
    branch_stall = (r[15:12] == 4'h0);
  endtask

  // Single jump in slot 0 with no register operands
  task automatic place_branch(inst_class_e cls, word_t target);
    clear_inputs();
    entries[0] = draw_entry();
    entries[0].dec_inst.inst_class    = cls;
    entries[0].dec_inst.branch_cond   = cond_always;
    entries[0].dec_inst.reg_target    = 1'b0;
    entries[0].dec_inst.a_reg_valid   = 1'b0;
    entries[0].dec_inst.b_reg_valid   = 1'b0;
    entries[0].dec_inst.branch_target = target;
    entry_valid[0] = 1'b1;
  endtask

  task automatic check_outputs();
    logic [n_units-1:0] used;
    logic [n_units-1:0] rdy;
    issue_op_t          exp_port [n_units];
    issue_op_t          act;
    logic               stop;
    logic               any;
    logic               npv;
    int                 unit;
    word_t              a;
    word_t              b;
    used = '0;
    stop = 1'b0;
    any  = 1'b0;
    rdy[unit_branch] = ~model_stall;
    rdy[unit_ls]     = ls_ready;
    rdy[unit_mul]    = mul_ready;
    for (int k = 0; k < alu_n; k++) begin
      rdy[unit_alu+k] = alu_ready[k];
    end
    for (int u = 0; u < n_units; u++) begin
      exp_port[u] = '0;
    end
    for (int i = 0; i < issue_w; i++) begin
      expect_hex($sformatf("rf_addr[%0d]", 2*i), rf_addr[2*i], entries[i].dec_inst.a_reg);
      expect_hex($sformatf("rf_addr[%0d]", 2*i+1), rf_addr[2*i+1], entries[i].dec_inst.b_reg);
      a = operand_value(rob_a[i], rf_data[2*i]);
      b = operand_value(rob_b[i], rf_data[2*i+1]);
      unit = -1;
      if (!stop && entry_valid[i] &&
          operand_ok(rob_a[i], entries[i].dec_inst.a_reg_valid) &&
          operand_ok(rob_b[i], entries[i].dec_inst.b_reg_valid)) begin
        unit = pick_unit(entries[i].dec_inst.inst_class, rdy & ~used);
      end
      if (unit >= 0) begin
        used[unit]     = 1'b1;
        exp_port[unit] = build_op(entries[i], a, b);
        any            = 1'b1;
      end else begin
        stop = 1'b1;
      end
      expect_hex($sformatf("consumed[%0d]", i), consumed[i], unit >= 0);
    end
    expect_hex("issue_enable", issue_enable, any);
    compare_port("ls_issue", ls_issue, exp_port[unit_ls]);
    compare_port("mul_issue", mul_issue, exp_port[unit_mul]);
    for (int k = 0; k < alu_n; k++) begin
      compare_port($sformatf("alu_issue[%0d]", k), alu_issue[k], exp_port[unit_alu+k]);
    end
    exp_branch = exp_port[unit_branch];
    act = model_stall ? model_held : exp_branch;
    npv = redirects(act);
    expect_hex("new_pc_valid", new_pc_valid, npv);
    expect_hex("branch_flush", branch_flush, npv & ~model_stall);
    if (npv) begin
      expect_hex("new_pc", new_pc, redirect_pc(act));
      expect_hex("flush_slot", flush_slot, act.rob_slot);
    end
    expect_hex("rob_wr_valid", rob_wr_valid, act.valid & ~branch_stall);
    if (act.valid && !branch_stall) begin
      expect_hex("rob_wr", rob_wr, link_write(act, npv));
    end
  endtask

  // Called shortly before the rising edge, returns on the next falling edge
  task automatic finish_cycle();
    check_outputs();
    @(posedge clock);
    advance_model(branch_stall, exp_branch);
    @(negedge clock);
  endtask

  task automatic report_test(string name, int errs_before);
    $display("Test %s done, %0d errors", name, n_errors - errs_before);
  endtask

  initial begin : main
    int   cycles;
    int   errs_before;
    logic accepted;

    seed       = 32'hb99a89f6;
    n_checks   = 0;
    n_errors   = 0;
    exp_branch = '0;
    reset_model();
    clear_inputs();

    cycles = 0;
    while (reset_n !== 1'b1 && cycles < 10) begin
      @(negedge clock);
      cycles++;
    end
    if (reset_n !== 1'b1) begin
      $display("Reset was not released within 10 cycles");
      $display("TEST FAIL");
      $finish;
    end

    // Empty queue first, then a jump to show the branch unit is ready
    errs_before = n_errors;
    clear_inputs();
    #15;
    expect_hex("new_pc_valid", new_pc_valid, 1'b0);
    expect_hex("branch_flush", branch_flush, 1'b0);
    finish_cycle();
    place_branch(cls_jump, 32'h0000_1000);
    #15;
    expect_hex("consumed[0]", consumed[0], 1'b1);
    finish_cycle();
    report_test("reset", errs_before);

    errs_before = n_errors;
    repeat (n_cycles) begin
      draw_stimulus();
      #15;
      finish_cycle();
    end
    // A stall drawn late in the random phase may still hold the branch unit
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < 4) begin
      place_branch(cls_jump, 32'h0000_0100);
      #15;
      accepted = consumed[0];
      finish_cycle();
      cycles++;
    end
    if (!accepted) begin
      n_errors++;
      $display("Branch unit stayed busy for 4 cycles after the random phase");
    end
    report_test("random issue", errs_before);

    // Jump captured on the first stalled cycle
    errs_before = n_errors;
    place_branch(cls_jump, 32'h0000_2000);
    branch_stall = 1'b1;
    #15;
    expect_hex("consumed[0]", consumed[0], 1'b1);
    expect_hex("rob_wr_valid", rob_wr_valid, 1'b0);
    finish_cycle();
    repeat (3) begin
      place_branch(cls_jump, 32'h0000_3000);
      branch_stall = 1'b1;
      #15;
      expect_hex("consumed[0]", consumed[0], 1'b0);
      expect_hex("new_pc", new_pc, 32'h0000_2000);
      expect_hex("rob_wr_valid", rob_wr_valid, 1'b0);
      finish_cycle();
    end
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < 6) begin
      place_branch(cls_jump, 32'h0000_3000);
      #15;
      accepted = consumed[0];
      finish_cycle();
      cycles++;
    end
    if (!accepted) begin
      n_errors++;
      $display("Branch unit took no new branch within 6 cycles after the stall ended");
    end else begin
      expect_hex("cycles to accept", cycles, 2);
    end
    report_test("stall hold", errs_before);

    $display("Checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+dv
src/iss_pkg.sv
src/iss_operand_read.sv
src/iss_dispatch.sv
src/iss_branch.sv
src/iss_top.sv
dv/iss_tb.sv

// ==== Bender.yml ====
package:
  name: iss

sources:
  - src/iss_pkg.sv
  - src/iss_operand_read.sv
  - src/iss_dispatch.sv
  - src/iss_branch.sv
  - src/iss_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/iss_tb.sv
